// ==== clint_pkg.sv ====
// CLINT package: bus widths, register offsets, response codes, payload structs, register select
package clint_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // register offsets inside the 64 KB window
  localparam logic [ADDR_W-1:0] MSIP_OFS     = 16'h0000;
  localparam logic [ADDR_W-1:0] MTIMECMP_OFS = 16'h4000;
  localparam logic [ADDR_W-1:0] MTIME_OFS    = 16'hBFF8;

  localparam logic [DATA_W-1:0] MTIMECMP_RST = 64'h0000_0000_0008_0000;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_DECERR = 2'd3;

  typedef enum logic [1:0] {
    SEL_NONE     = 2'd0,
    SEL_MSIP     = 2'd1,
    SEL_MTIMECMP = 2'd2,
    SEL_MTIME    = 2'd3
  } reg_sel_t;

  // AR and AW request payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } addr_pay_t;

  // W payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } wdata_pay_t;

endpackage

// ==== clint_reg_if.sv ====
// register access interface between the AXI control FSMs, the CSR bank and the mtime counter
`timescale 1ns/1ps

interface clint_reg_if;
  import clint_pkg::*;

  // read side, select comes straight from the buffered AR address
  reg_sel_t          rd_sel;
  logic [DATA_W-1:0] rdata;

  // write side, wr_en is a single-cycle pulse
  logic              wr_en;
  reg_sel_t          wr_sel;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] wmask;

  modport ctrl (
    output rd_sel, wr_en, wr_sel, wdata, wmask,
    input  rdata
  );

  modport bank (
    input  rd_sel, wr_en, wr_sel, wdata, wmask,
    output rdata
  );

  modport timer (
    input wr_en, wr_sel, wdata, wmask
  );

endinterface

// ==== clint_chan_buf.sv ====
// one-entry valid/ready holding buffer for a generic request payload
`timescale 1ns/1ps

module clint_chan_buf #(
  parameter type pay_t = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  pay_t in_pay_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output pay_t out_pay_o
);

  logic full;
  pay_t pay_q;

  // free when empty, or when the held entry leaves this cycle
  assign in_ready_o  = !full || out_ready_i;
  assign out_valid_o = full;
  assign out_pay_o   = pay_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_ready_o) begin
      full <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      pay_q <= in_pay_i;
    end
  end

endmodule

// ==== clint_axi_ctrl.sv ====
// AXI read and write FSMs, offset decode, response generation and register interface drive
`timescale 1ns/1ps

module clint_axi_ctrl (
  input  logic                         clk,
  input  logic                         rst,

  input  logic                         ar_valid_i,
  output logic                         ar_ready_o,
  input  clint_pkg::addr_pay_t         ar_pay_i,

  input  logic                         aw_valid_i,
  output logic                         aw_ready_o,
  input  clint_pkg::addr_pay_t         aw_pay_i,

  input  logic                         w_valid_i,
  output logic                         w_ready_o,
  input  clint_pkg::wdata_pay_t        w_pay_i,

  output logic                         r_valid_o,
  input  logic                         r_ready_i,
  output logic [clint_pkg::DATA_W-1:0] r_data_o,
  output logic [1:0]                   r_resp_o,
  output logic [clint_pkg::ID_W-1:0]   r_id_o,

  output logic                         b_valid_o,
  input  logic                         b_ready_i,
  output logic [1:0]                   b_resp_o,
  output logic [clint_pkg::ID_W-1:0]   b_id_o,

  clint_reg_if.ctrl                    regs
);
  import clint_pkg::*;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RESP = 1'b1
  } chan_state_t;

  chan_state_t rd_state;
  chan_state_t wr_state;

  reg_sel_t rd_dec;
  reg_sel_t wr_dec;
  logic     rd_accept;
  logic     wr_accept;

  function automatic reg_sel_t decode(input logic [ADDR_W-1:0] addr);
    reg_sel_t sel;
    case (addr)
      MSIP_OFS:     sel = SEL_MSIP;
      MTIMECMP_OFS: sel = SEL_MTIMECMP;
      MTIME_OFS:    sel = SEL_MTIME;
      default:      sel = SEL_NONE;
    endcase
    return sel;
  endfunction

  assign rd_dec = decode(ar_pay_i.addr);
  assign wr_dec = decode(aw_pay_i.addr);

  // read path
  assign ar_ready_o = (rd_state == ST_IDLE);
  assign rd_accept  = ar_valid_i && ar_ready_o;
  assign r_valid_o  = (rd_state == ST_RESP);

  assign regs.rd_sel = rd_dec;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= ST_IDLE;
    end else begin
      case (rd_state)
        ST_IDLE: if (rd_accept) rd_state <= ST_RESP;
        ST_RESP: if (r_ready_i) rd_state <= ST_IDLE;
        default: rd_state <= ST_IDLE;
      endcase
    end
  end

  // capture data, id and response on acceptance, held until R handshake
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      r_id_o <= ar_pay_i.id;
      if (rd_dec == SEL_NONE) begin
        r_data_o <= '0;
        r_resp_o <= RESP_DECERR;
      end else begin
        r_data_o <= regs.rdata;
        r_resp_o <= RESP_OKAY;
      end
    end
  end

  // write path, AW and W are taken together
  assign wr_accept  = (wr_state == ST_IDLE) && aw_valid_i && w_valid_i;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign b_valid_o  = (wr_state == ST_RESP);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= ST_IDLE;
    end else begin
      case (wr_state)
        ST_IDLE: if (wr_accept) wr_state <= ST_RESP;
        ST_RESP: if (b_ready_i) wr_state <= ST_IDLE;
        default: wr_state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      b_id_o   <= aw_pay_i.id;
      b_resp_o <= (wr_dec == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
    end
  end

  // no register pulse for unmapped offsets
  assign regs.wr_en  = wr_accept && (wr_dec != SEL_NONE);
  assign regs.wr_sel = wr_dec;
  assign regs.wdata  = w_pay_i.data;

  // byte strobes to bit mask
  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      regs.wmask[8*i +: 8] = {8{w_pay_i.strb[i]}};
    end
  end

endmodule

// ==== clint_csr_bank.sv ====
// msip and mtimecmp registers, register read mux, software and timer interrupts
`timescale 1ns/1ps

module clint_csr_bank (
  input  logic                         clk,
  input  logic                         rst,
  clint_reg_if.bank                    regs,
  input  logic [clint_pkg::DATA_W-1:0] mtime_i,
  output logic                         soft_irq_o,
  output logic                         timer_irq_o
);
  import clint_pkg::*;

  logic              msip;
  logic [DATA_W-1:0] mtimecmp;
  logic              msip_wr;
  logic              mtimecmp_wr;

  assign msip_wr     = regs.wr_en && (regs.wr_sel == SEL_MSIP);
  assign mtimecmp_wr = regs.wr_en && (regs.wr_sel == SEL_MTIMECMP);

  // only bit 0 of msip exists
  always_ff @(posedge clk) begin
    if (rst) begin
      msip <= 1'b0;
    end else if (msip_wr) begin
      msip <= (msip & ~regs.wmask[0]) | (regs.wdata[0] & regs.wmask[0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp <= MTIMECMP_RST;
    end else if (mtimecmp_wr) begin
      mtimecmp <= (mtimecmp & ~regs.wmask) | (regs.wdata & regs.wmask);
    end
  end

  always_comb begin
    case (regs.rd_sel)
      SEL_MSIP:     regs.rdata = {{(DATA_W-1){1'b0}}, msip};
      SEL_MTIMECMP: regs.rdata = mtimecmp;
      SEL_MTIME:    regs.rdata = mtime_i;
      default:      regs.rdata = '0;
    endcase
  end

  // interrupt levels to the hart
  always_ff @(posedge clk) begin
    if (rst) begin
      soft_irq_o  <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      soft_irq_o  <= msip;
      timer_irq_o <= (mtime_i >= mtimecmp);
    end
  end

endmodule

// ==== clint_mtime.sv ====
// mtime counter driven by rising edges of the real-time tick, with masked bus write
`timescale 1ns/1ps

module clint_mtime (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         rtc_tick_i,
  clint_reg_if.timer                   regs,
  output logic [clint_pkg::DATA_W-1:0] mtime_o
);
  import clint_pkg::*;

  logic tick_q;
  logic tick_rise;
  logic mtime_wr;

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_q <= 1'b0;
    end else begin
      tick_q <= rtc_tick_i;
    end
  end

  assign tick_rise = rtc_tick_i && !tick_q;
  assign mtime_wr  = regs.wr_en && (regs.wr_sel == SEL_MTIME);

  // bus write wins over a tick in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_o <= '0;
    end else if (mtime_wr) begin
      mtime_o <= (mtime_o & ~regs.wmask) | (regs.wdata & regs.wmask);
    end else if (tick_rise) begin
      mtime_o <= mtime_o + 1'b1;
    end
  end

endmodule

// ==== clint_top.sv ====
// CLINT top level: AXI request buffers, control FSMs, CSR bank and mtime counter
`timescale 1ns/1ps

module clint_top (
  input  logic                         clk,
  input  logic                         rst,

  input  logic                         aw_valid_i,
  output logic                         aw_ready_o,
  input  logic [clint_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [clint_pkg::ID_W-1:0]   aw_id_i,

  input  logic                         w_valid_i,
  output logic                         w_ready_o,
  input  logic [clint_pkg::DATA_W-1:0] w_data_i,
  input  logic [clint_pkg::STRB_W-1:0] w_strb_i,

  output logic                         b_valid_o,
  input  logic                         b_ready_i,
  output logic [1:0]                   b_resp_o,
  output logic [clint_pkg::ID_W-1:0]   b_id_o,

  input  logic                         ar_valid_i,
  output logic                         ar_ready_o,
  input  logic [clint_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic [clint_pkg::ID_W-1:0]   ar_id_i,

  output logic                         r_valid_o,
  input  logic                         r_ready_i,
  output logic [clint_pkg::DATA_W-1:0] r_data_o,
  output logic [1:0]                   r_resp_o,
  output logic [clint_pkg::ID_W-1:0]   r_id_o,

  input  logic                         rtc_tick_i,
  output logic                         soft_irq_o,
  output logic                         timer_irq_o
);
  import clint_pkg::*;

  addr_pay_t  ar_pay_in;
  addr_pay_t  ar_pay;
  addr_pay_t  aw_pay_in;
  addr_pay_t  aw_pay;
  wdata_pay_t w_pay_in;
  wdata_pay_t w_pay;

  logic ar_buf_valid;
  logic ar_buf_ready;
  logic aw_buf_valid;
  logic aw_buf_ready;
  logic w_buf_valid;
  logic w_buf_ready;

  logic [DATA_W-1:0] mtime;

  clint_reg_if regs ();

  assign ar_pay_in = '{addr: ar_addr_i, id: ar_id_i};
  assign aw_pay_in = '{addr: aw_addr_i, id: aw_id_i};
  assign w_pay_in  = '{data: w_data_i, strb: w_strb_i};

  clint_chan_buf #(.pay_t(addr_pay_t)) u_ar_buf (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (ar_valid_i),
    .in_ready_o  (ar_ready_o),
    .in_pay_i    (ar_pay_in),
    .out_valid_o (ar_buf_valid),
    .out_ready_i (ar_buf_ready),
    .out_pay_o   (ar_pay)
  );

  clint_chan_buf #(.pay_t(addr_pay_t)) u_aw_buf (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (aw_valid_i),
    .in_ready_o  (aw_ready_o),
    .in_pay_i    (aw_pay_in),
    .out_valid_o (aw_buf_valid),
    .out_ready_i (aw_buf_ready),
    .out_pay_o   (aw_pay)
  );

  clint_chan_buf #(.pay_t(wdata_pay_t)) u_w_buf (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (w_valid_i),
    .in_ready_o  (w_ready_o),
    .in_pay_i    (w_pay_in),
    .out_valid_o (w_buf_valid),
    .out_ready_i (w_buf_ready),
    .out_pay_o   (w_pay)
  );

  clint_axi_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_buf_valid),
    .ar_ready_o (ar_buf_ready),
    .ar_pay_i   (ar_pay),
    .aw_valid_i (aw_buf_valid),
    .aw_ready_o (aw_buf_ready),
    .aw_pay_i   (aw_pay),
    .w_valid_i  (w_buf_valid),
    .w_ready_o  (w_buf_ready),
    .w_pay_i    (w_pay),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_id_o     (r_id_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .b_id_o     (b_id_o),
    .regs       (regs.ctrl)
  );

  clint_csr_bank u_csr_bank (
    .clk         (clk),
    .rst         (rst),
    .regs        (regs.bank),
    .mtime_i     (mtime),
    .soft_irq_o  (soft_irq_o),
    .timer_irq_o (timer_irq_o)
  );

  clint_mtime u_mtime (
    .clk        (clk),
    .rst        (rst),
    .rtc_tick_i (rtc_tick_i),
    .regs       (regs.timer),
    .mtime_o    (mtime)
  );

endmodule

// ==== tb_clint_tasks.svh ====
// AXI write and read tasks, tick pulses, response drain and the test sequences
`ifndef TB_CLINT_TASKS_SVH
`define TB_CLINT_TASKS_SVH

  task automatic drain;
    while (exp_r_q.size() != 0 || exp_b_q.size() != 0) @(negedge clk);
  endtask

  // called and returns on a falling edge
  task automatic axi_write(input logic [15:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input logic [3:0] id);
    logic aw_hs;
    logic w_hs;
    logic aw_done;
    logic w_done;
    exp_b_q.push_back({id, ref_resp(addr)});
    model_write(addr, data, strb);
    aw_valid_i = 1'b1;
    aw_addr_i = addr;
    aw_id_i = id;
    w_valid_i = 1'b1;
    w_data_i = data;
    w_strb_i = strb;
    aw_done = 1'b0;
    w_done = 1'b0;
    while (!(aw_done && w_done)) begin
      aw_hs = aw_valid_i && aw_ready_o;
      w_hs = w_valid_i && w_ready_o;
      @(negedge clk);
      if (aw_hs) begin
        aw_valid_i = 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        w_valid_i = 1'b0;
        w_done = 1'b1;
      end
    end
    if (!bp_mode) drain();
  endtask

  task automatic axi_read(input logic [15:0] addr, input logic [3:0] id);
    exp_r_q.push_back({id, ref_resp(addr), ref_data(addr)});
    ar_valid_i = 1'b1;
    ar_addr_i = addr;
    ar_id_i = id;
    while (!ar_ready_o) @(negedge clk);
    @(negedge clk);
    ar_valid_i = 1'b0;
    if (!bp_mode) drain();
  endtask

  // level held for one to four cycles and counted once, irq settled on return
  task automatic tick_pulse;
    logic [63:0] h;
    rand_bits(2, h);
    rtc_tick_i = 1'b1;
    repeat (int'(h[1:0]) + 1) @(negedge clk);
    rtc_tick_i = 1'b0;
    @(negedge clk);
    m_mtime = m_mtime + 64'd1;
  endtask

  task automatic test_reset;
    test_name = "reset";
    check_irqs();
    axi_read(MSIP_OFS, 4'h1);
    axi_read(MTIMECMP_OFS, 4'h2);
    axi_read(MTIME_OFS, 4'h3);
  endtask

  task automatic test_masked;
    logic [63:0] d;
    logic [63:0] s;
    logic [63:0] id;
    test_name = "masked_write";
    repeat (N_MASK) begin
      rand_bits(64, d);
      rand_bits(8, s);
      rand_bits(4, id);
      axi_write(MTIMECMP_OFS, d, s[7:0], id[3:0]);
      rand_bits(64, d);
      rand_bits(8, s);
      axi_write(MTIME_OFS, d, s[7:0], id[3:0]);
      rand_bits(64, d);
      rand_bits(8, s);
      axi_write(MSIP_OFS, d, s[7:0], id[3:0]);
      check_irqs();
      axi_read(MTIMECMP_OFS, id[3:0]);
      axi_read(MTIME_OFS, id[3:0]);
      axi_read(MSIP_OFS, id[3:0]);
    end
    // msip set from all ones, then cleared through byte 0 alone
    axi_write(MSIP_OFS, 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF, 4'hF);
    check_irqs();
    axi_read(MSIP_OFS, 4'hF);
    axi_write(MSIP_OFS, 64'd0, 8'h01, 4'hE);
    check_irqs();
  endtask

  task automatic test_ticks;
    logic [63:0] d;
    test_name = "tick_count";
    rand_bits(32, d);
    axi_write(MTIME_OFS, {32'd0, d[31:0]}, 8'hFF, 4'h4);
    repeat (N_TICK) tick_pulse();
    axi_read(MTIME_OFS, 4'h5);
  endtask

  task automatic test_timer;
    test_name = "timer_irq";
    axi_write(MTIMECMP_OFS, m_mtime + 64'(TIMER_K), 8'hFF, 4'h6);
    repeat (TIMER_K) begin
      check_irqs();
      tick_pulse();
    end
    check_irqs();
    // compare moved above mtime again
    axi_write(MTIMECMP_OFS, m_mtime + 64'd100, 8'hFF, 4'h7);
    check_irqs();
  endtask

  task automatic test_unmapped;
    logic [63:0] d;
    test_name = "unmapped";
    axi_read(16'h0008, 4'h8);
    axi_read(16'h4004, 4'h9);
    axi_read(16'hBFF0, 4'hA);
    rand_bits(64, d);
    axi_write(16'h0010, d, 8'hFF, 4'hB);
    axi_write(16'hBFFC, d, 8'hFF, 4'hC);
    axi_read(MSIP_OFS, 4'hD);
    axi_read(MTIMECMP_OFS, 4'hD);
    axi_read(MTIME_OFS, 4'hD);
  endtask

  // reads stay off mtimecmp, which only the writes touch here
  task automatic bp_reads;
    logic [63:0] r;
    logic [15:0] a;
    repeat (N_BP) begin
      rand_bits(6, r);
      case (r[1:0])
        2'd0:    a = MSIP_OFS;
        2'd1:    a = MTIME_OFS;
        default: a = 16'h0100;
      endcase
      axi_read(a, r[5:2]);
    end
  endtask

  task automatic bp_writes;
    logic [63:0] d;
    logic [63:0] s;
    logic [63:0] r;
    repeat (N_BP) begin
      rand_bits(64, d);
      rand_bits(8, s);
      rand_bits(5, r);
      axi_write(r[0] ? MTIMECMP_OFS : 16'h4008, d, s[7:0], r[4:1]);
    end
  endtask

  task automatic stall_ready;
    logic [63:0] r;
    while (!bp_done) begin
      rand_bits(2, r);
      r_ready_i = r[0];
      b_ready_i = r[1];
      @(negedge clk);
    end
    r_ready_i = 1'b1;
    b_ready_i = 1'b1;
  endtask

  task automatic test_backpressure;
    test_name = "backpressure";
    bp_mode = 1'b1;
    bp_done = 1'b0;
    fork
      begin
        fork
          bp_reads();
          bp_writes();
        join
        drain();
        bp_done = 1'b1;
      end
      stall_ready();
    join
    bp_mode = 1'b0;
    axi_read(MTIMECMP_OFS, 4'hE);
  endtask

`endif

// ==== tb_clint.sv ====
// testbench top for the CLINT: clock, reset, watchdog, LFSR, reference model, response compare
`timescale 1ns/1ps

module tb_clint;
  import clint_pkg::*;

  localparam int CLK_NS    = 4;
  localparam int RST_CYC   = 10;
  localparam int N_MASK    = 8;
  localparam int N_TICK    = 12;
  localparam int TIMER_K   = 5;
  localparam int N_BP      = 24;
  localparam int TRANS_CYC = 50;
  // reads, writes and tick pulses of all tests together
  localparam int N_TRANS   = 3 + 6 * N_MASK + 3 + 2 + N_TICK + 2 + TIMER_K + 8 + 2 * N_BP + 1;
  localparam int WATCHDOG_NS = (N_TRANS * TRANS_CYC + RST_CYC) * CLK_NS;

  logic        clk;
  logic        rst;
  logic        aw_valid_i;
  logic        aw_ready_o;
  logic [15:0] aw_addr_i;
  logic [3:0]  aw_id_i;
  logic        w_valid_i;
  logic        w_ready_o;
  logic [63:0] w_data_i;
  logic [7:0]  w_strb_i;
  logic        b_valid_o;
  logic        b_ready_i;
  logic [1:0]  b_resp_o;
  logic [3:0]  b_id_o;
  logic        ar_valid_i;
  logic        ar_ready_o;
  logic [15:0] ar_addr_i;
  logic [3:0]  ar_id_i;
  logic        r_valid_o;
  logic        r_ready_i;
  logic [63:0] r_data_o;
  logic [1:0]  r_resp_o;
  logic [3:0]  r_id_o;
  logic        rtc_tick_i;
  logic        soft_irq_o;
  logic        timer_irq_o;

  logic [15:0] lfsr;
  logic        m_msip;
  logic [63:0] m_mtimecmp;
  logic [63:0] m_mtime;
  // {id, resp, data} and {id, resp}
  logic [69:0] exp_r_q[$];
  logic [5:0]  exp_b_q[$];
  string       test_name;
  int          err_resp;
  int          err_other;
  int          err_irq;
  logic        bp_mode;
  logic        bp_done;

  clint_top uut (
    .clk         (clk),
    .rst         (rst),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .aw_addr_i   (aw_addr_i),
    .aw_id_i     (aw_id_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_data_i    (w_data_i),
    .w_strb_i    (w_strb_i),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .b_resp_o    (b_resp_o),
    .b_id_o      (b_id_o),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_addr_i   (ar_addr_i),
    .ar_id_i     (ar_id_i),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .r_id_o      (r_id_o),
    .rtc_tick_i  (rtc_tick_i),
    .soft_irq_o  (soft_irq_o),
    .timer_irq_o (timer_irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = 64'd0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] data,
                                        input logic [7:0] strb);
    logic [63:0] res;
    for (int i = 0; i < 8; i++) begin
      res[8*i +: 8] = strb[i] ? data[8*i +: 8] : old[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [1:0] ref_resp(input logic [15:0] addr);
    if (addr == MSIP_OFS || addr == MTIMECMP_OFS || addr == MTIME_OFS) begin
      return RESP_OKAY;
    end
    return RESP_DECERR;
  endfunction

  function automatic logic [63:0] ref_data(input logic [15:0] addr);
    logic [63:0] d;
    case (addr)
      MSIP_OFS:     d = {63'd0, m_msip};
      MTIMECMP_OFS: d = m_mtimecmp;
      MTIME_OFS:    d = m_mtime;
      default:      d = 64'd0;
    endcase
    return d;
  endfunction

  // unmapped offsets leave the model alone
  task automatic model_write(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
    logic [63:0] m;
    case (addr)
      MSIP_OFS: begin
        m = merge({63'd0, m_msip}, data, strb);
        m_msip = m[0];
      end
      MTIMECMP_OFS: m_mtimecmp = merge(m_mtimecmp, data, strb);
      MTIME_OFS:    m_mtime = merge(m_mtime, data, strb);
      default:      m = 64'd0;
    endcase
  endtask

  task automatic check_irqs;
    logic exp_timer;
    exp_timer = (m_mtime >= m_mtimecmp);
    if (soft_irq_o !== m_msip) begin
      err_irq++;
      $display("error %s soft_irq: expected %b, actual %b", test_name, m_msip, soft_irq_o);
    end
    if (timer_irq_o !== exp_timer) begin
      err_irq++;
      $display("error %s timer_irq: expected %b, actual %b", test_name, exp_timer, timer_irq_o);
    end
  endtask

  // every R and B handshake against the expected queues
  always @(posedge clk) begin : compare_resp
    logic [69:0] er;
    logic [5:0]  eb;
    if (!rst && r_valid_o && r_ready_i) begin
      if (exp_r_q.size() == 0) begin
        err_other++;
        $display("unexpected read response with id %h during %s", r_id_o, test_name);
      end else begin
        er = exp_r_q.pop_front();
        if (r_id_o !== er[69:66]) begin
          err_resp++;
          $display("error %s r_id: expected %h, actual %h", test_name, er[69:66], r_id_o);
        end
        if (r_resp_o !== er[65:64]) begin
          err_resp++;
          $display("error %s r_resp: expected %h, actual %h", test_name, er[65:64], r_resp_o);
        end
        if (r_data_o !== er[63:0]) begin
          err_resp++;
          $display("error %s r_data: expected %h, actual %h", test_name, er[63:0], r_data_o);
        end
      end
    end
    if (!rst && b_valid_o && b_ready_i) begin
      if (exp_b_q.size() == 0) begin
        err_other++;
        $display("unexpected write response with id %h during %s", b_id_o, test_name);
      end else begin
        eb = exp_b_q.pop_front();
        if (b_id_o !== eb[5:2]) begin
          err_resp++;
          $display("error %s b_id: expected %h, actual %h", test_name, eb[5:2], b_id_o);
        end
        if (b_resp_o !== eb[1:0]) begin
          err_resp++;
          $display("error %s b_resp: expected %h, actual %h", test_name, eb[1:0], b_resp_o);
        end
      end
    end
  end

`include "tb_clint_tasks.svh"

  initial begin
    rst = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i = 16'd0;
    aw_id_i = 4'd0;
    w_valid_i = 1'b0;
    w_data_i = 64'd0;
    w_strb_i = 8'd0;
    b_ready_i = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i = 16'd0;
    ar_id_i = 4'd0;
    r_ready_i = 1'b1;
    rtc_tick_i = 1'b0;
    lfsr = 16'd39;
    bp_mode = 1'b0;
    bp_done = 1'b0;
    err_resp = 0;
    err_other = 0;
    err_irq = 0;
    test_name = "init";
    m_msip = 1'b0;
    m_mtimecmp = 64'h0000_0000_0008_0000;
    m_mtime = 64'd0;
    repeat (RST_CYC) @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_masked();
    test_ticks();
    test_timer();
    test_unmapped();
    test_backpressure();

    $display("errors: %0d response mismatches, %0d interrupt mismatches, %0d other failures",
             err_resp, err_irq, err_other);
    if (err_resp == 0 && err_irq == 0 && err_other == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns in %s, responses still missing", WATCHDOG_NS, test_name);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
clint_pkg.sv
clint_reg_if.sv
clint_chan_buf.sv
clint_axi_ctrl.sv
clint_csr_bank.sv
clint_mtime.sv
clint_top.sv
tb_clint.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_clint -o tb_clint_sim

./obj_dir/tb_clint_sim > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without a failure report"
exit 0
